// File: sinh_matrix_input.txt
# Record: T <test> <height> <width> <stray J strobe while busy, 0 or 1>
# Element, row by row: <input Q4.12 hex> <expected sinh Q4.12 hex>
T 1 1 1 0
0000 0000

T 2 1 5 0
1000 12cd
f000 ed31
0010 0010
0c00 0d28
f400 f2d5

T 3 3 4 0
0400 040a
fc00 fbf3
0800 0856
f800 f7a7
1800 2211
e800 ddec
0001 0001
ffff ffff
0c00 0d28
1000 12cd
fff0 fff0
0000 0000

T 4 1 4 0
2000 3a05
e000 c5f9
0001 0001
ffff ffff

T 5 2 2 0
f800 f7a7
0800 0856
e800 ddec
1800 2211

T 6 2 3 1
1000 12cd
f000 ed31
0400 040a
fc00 fbf3
2000 3a05
e000 c5f9

// File: sinh_matrix_sequencer.f
+incdir+.
sinh_pkg.sv
sinh_scalar_series.sv
sinh_vector_sequencer.sv
sinh_matrix_sequencer.sv
tb_sinh_matrix_sequencer.sv

// File: sinh_matrix_sequencer.sv
//////////////////////////////
// Element-wise sinh over a matrix, top level
// START latches SIZE_I_IN and SIZE_J_IN, ignored while running
// DATA_IN_I_ENABLE opens a row, DATA_IN_J_ENABLE carries the rest
// DATA_OUT_J_ENABLE follows each accepted strobe by 10 cycles
// One element in flight, no back-pressure
// Sizes of zero are not supported
//////////////////////////////

`timescale 1ns/1ps

module sinh_matrix_sequencer
  import sinh_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,
  input  logic  START,
  input  logic  DATA_IN_I_ENABLE,
  input  logic  DATA_IN_J_ENABLE,
  input  size_t SIZE_I_IN,
  input  size_t SIZE_J_IN,
  input  data_t DATA_IN,
  output logic  READY,
  output logic  DATA_OUT_I_ENABLE,
  output logic  DATA_OUT_J_ENABLE,
  output data_t DATA_OUT
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  matrix_state_t state;

  // Latched sizes and current row
  size_t size_i_q;
  size_t size_j_q;
  size_t row_idx;

  // Vector sequencer side
  logic         vec_start;
  logic         vec_elem_valid;
  sinh_result_t vec_out;
  logic         row_done;
  logic         last_row;

  // Row opens on I strobe only
  assign vec_start = (state == mat_wait_row) && DATA_IN_I_ENABLE;

  // J strobes pass only inside a row
  assign vec_elem_valid = vec_start ||
                          ((state == mat_run_row) && DATA_IN_J_ENABLE);

  assign last_row = (row_idx == size_t'(size_i_q - size_t'(1)));

  //////////////////////////////
  // Vector sequencer
  //////////////////////////////

  sinh_vector_sequencer u_vector (
    .CLK        (CLK),
    .RST        (RST),
    .start      (vec_start),
    .row_len    (size_j_q),
    .elem_valid (vec_elem_valid),
    .elem       (DATA_IN),
    .elem_out   (vec_out),
    .row_done   (row_done)
  );

  //////////////////////////////
  // Matrix FSM and outputs
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= mat_idle;
      size_i_q          <= '0;
      size_j_q          <= '0;
      row_idx           <= '0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT          <= '0;
    end else begin
      // Strobes are single-cycle
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;

      // Every result goes out, DATA_OUT holds until the next one
      if (vec_out.valid) begin
        DATA_OUT_J_ENABLE <= 1'b1;
        DATA_OUT          <= vec_out.data;
      end

      case (state)
        mat_idle: begin
          if (START) begin
            size_i_q <= SIZE_I_IN;
            size_j_q <= SIZE_J_IN;
            row_idx  <= '0;
            state    <= mat_wait_row;
          end
        end
        mat_wait_row: begin
          // Vector sequencer started this cycle
          if (DATA_IN_I_ENABLE) begin
            state <= mat_run_row;
          end
        end
        mat_run_row: begin
          // End of row lines up with its last J strobe
          if (row_done) begin
            if (last_row) begin
              READY <= 1'b1;
              state <= mat_idle;
            end else begin
              DATA_OUT_I_ENABLE <= 1'b1;
              row_idx           <= row_idx + 1'b1;
              state             <= mat_wait_row;
            end
          end
        end
        default: begin
          state <= mat_idle;
        end
      endcase
    end
  end

endmodule

// File: sinh_params.svh
//////////////////////////////
// Widths and constants for the sinh accelerator
// Elements are Q4.12 signed, inputs limited to magnitude 2.0
// Reciprocals are Q4.12, rounded to nearest
// No overflow saturation anywhere in the datapath
//////////////////////////////

`ifndef SINH_PARAMS_SVH
`define SINH_PARAMS_SVH

// Element width and fraction bits
`define SINH_DATA_W 16
`define SINH_FRAC   12

// Matrix dimension and index width
`define SINH_SIZE_W 8

// Series terms x, x^3/6, x^5/120, x^7/5040
`define SINH_TERMS  4

// 1/6, 1/20, 1/42 in Q4.12
`define SINH_RECIP_1 683
`define SINH_RECIP_2 205
`define SINH_RECIP_3 98

`endif

// File: sinh_pkg.sv
//////////////////////////////
// Shared types for the sinh accelerator
// Widths come from the params header
//////////////////////////////

`include "sinh_params.svh"

package sinh_pkg;

  // Q4.12 element value
  typedef logic signed [`SINH_DATA_W-1:0] data_t;

  // Matrix dimension or index
  typedef logic [`SINH_SIZE_W-1:0] size_t;

  // Series term counter
  typedef logic [$clog2(`SINH_TERMS)-1:0] term_t;

  // Scalar unit FSM
  typedef enum logic [2:0] {
    series_idle,
    series_square,
    series_scale_x2,
    series_scale_recip,
    series_done
  } series_state_t;

  // Row FSM
  typedef enum logic [1:0] {
    row_idle,
    row_wait_elem,
    row_busy
  } row_state_t;

  // Matrix FSM
  typedef enum logic [1:0] {
    mat_idle,
    mat_wait_row,
    mat_run_row
  } matrix_state_t;

  // One result moving up a layer, valid is a single-cycle pulse
  typedef struct packed {
    logic  valid;
    data_t data;
  } sinh_result_t;

endpackage

// File: sinh_scalar_series.sv
//////////////////////////////
// sinh(x) as x + x^3/6 + x^5/120 + x^7/5040 with one multiplier
// result.valid pulses 8 cycles after start
// start is ignored while a value is in progress
// Intermediates run at double width so x^3 at |x| = 2 does not wrap
// Every product is floored by an arithmetic shift of SINH_FRAC
//////////////////////////////

`timescale 1ns/1ps
`include "sinh_params.svh"

module sinh_scalar_series
  import sinh_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         start,
  input  data_t        operand,
  output sinh_result_t result
);

  // Internal width, and width of the raw product
  localparam int ACC_W  = 2 * `SINH_DATA_W;
  localparam int PROD_W = 2 * ACC_W;

  // Index of the x^7 term, counting from x^3 as zero
  localparam term_t LAST_TERM = term_t'(`SINH_TERMS - 2);

  //////////////////////////////
  // Signals
  //////////////////////////////

  series_state_t state;
  term_t         term_idx;

  // Operand, its square, current term, half-scaled term, running sum
  logic signed [ACC_W-1:0] x_q;
  logic signed [ACC_W-1:0] x2_q;
  logic signed [ACC_W-1:0] term_q;
  logic signed [ACC_W-1:0] tmp_q;
  logic signed [ACC_W-1:0] sum_q;

  // Shared multiplier
  logic signed [ACC_W-1:0]  mul_a;
  logic signed [ACC_W-1:0]  mul_b;
  logic signed [ACC_W-1:0]  recip;
  logic signed [PROD_W-1:0] product;
  logic signed [ACC_W-1:0]  scaled;

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // Reciprocal for the term being built
  always_comb begin
    case (term_idx)
      2'd0:    recip = ACC_W'(`SINH_RECIP_1);
      2'd1:    recip = ACC_W'(`SINH_RECIP_2);
      default: recip = ACC_W'(`SINH_RECIP_3);
    endcase
  end

  // Multiplier steering by state
  always_comb begin
    case (state)
      series_square: begin
        mul_a = x_q;
        mul_b = x_q;
      end
      series_scale_x2: begin
        mul_a = term_q;
        mul_b = x2_q;
      end
      series_scale_recip: begin
        mul_a = tmp_q;
        mul_b = recip;
      end
      default: begin
        mul_a = '0;
        mul_b = '0;
      end
    endcase
  end

  assign product = mul_a * mul_b;

  // Arithmetic shift right by the fraction width, then truncate
  assign scaled = product[`SINH_FRAC +: ACC_W];

  // Payload registers
  always_ff @(posedge CLK) begin
    case (state)
      series_idle: begin
        if (start) begin
          // Series starts with the x term
          x_q    <= operand;
          term_q <= operand;
          sum_q  <= operand;
        end
      end
      series_square: begin
        x2_q <= scaled;
      end
      series_scale_x2: begin
        tmp_q <= scaled;
      end
      series_scale_recip: begin
        term_q <= scaled;
        sum_q  <= sum_q + scaled;
      end
      default: begin
      end
    endcase
  end

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= series_idle;
      term_idx <= '0;
      result   <= '0;
    end else begin
      result.valid <= 1'b0;
      case (state)
        series_idle: begin
          if (start) begin
            state <= series_square;
          end
        end
        series_square: begin
          term_idx <= '0;
          state    <= series_scale_x2;
        end
        series_scale_x2: begin
          state <= series_scale_recip;
        end
        series_scale_recip: begin
          // Two multiplies per higher term
          if (term_idx == LAST_TERM) begin
            state <= series_done;
          end else begin
            term_idx <= term_idx + 1'b1;
            state    <= series_scale_x2;
          end
        end
        series_done: begin
          // Sum fits the element width for |x| <= 2
          result.valid <= 1'b1;
          result.data  <= sum_q[`SINH_DATA_W-1:0];
          state        <= series_idle;
        end
        default: begin
          state <= series_idle;
        end
      endcase
    end
  end

endmodule

// File: sinh_vector_sequencer.sv
//////////////////////////////
// Runs one row of elements through the scalar unit
// start may come with the first elem_valid of the row
// elem_out.valid follows each accepted element by 9 cycles
// row_done pulses with the valid of the last element
// row_len of zero is not supported
//////////////////////////////

`timescale 1ns/1ps

module sinh_vector_sequencer
  import sinh_pkg::*;
(
  input  logic         CLK,
  input  logic         RST,
  input  logic         start,
  input  size_t        row_len,
  input  logic         elem_valid,
  input  data_t        elem,
  output sinh_result_t elem_out,
  output logic         row_done
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  row_state_t   state;
  size_t        row_len_q;
  size_t        col_idx;
  sinh_result_t scal_result;

  // Element taken this cycle
  logic accept;
  logic last_col;

  // Element accepted when waiting, or together with start
  assign accept = elem_valid &&
                  ((state == row_wait_elem) || ((state == row_idle) && start));

  assign last_col = (col_idx == size_t'(row_len_q - size_t'(1)));

  //////////////////////////////
  // Scalar unit
  //////////////////////////////

  // Scalar unit latches elem itself on start
  sinh_scalar_series u_scalar (
    .CLK     (CLK),
    .RST     (RST),
    .start   (accept),
    .operand (elem),
    .result  (scal_result)
  );

  //////////////////////////////
  // Row FSM
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= row_idle;
      row_len_q <= '0;
      col_idx   <= '0;
      elem_out  <= '0;
      row_done  <= 1'b0;
    end else begin
      elem_out.valid <= 1'b0;
      row_done       <= 1'b0;
      case (state)
        row_idle: begin
          if (start) begin
            row_len_q <= row_len;
            col_idx   <= '0;
            // First element may already be here
            state     <= accept ? row_busy : row_wait_elem;
          end
        end
        row_wait_elem: begin
          if (accept) begin
            state <= row_busy;
          end
        end
        row_busy: begin
          // Strobes seen here are dropped
          if (scal_result.valid) begin
            elem_out <= scal_result;
            if (last_col) begin
              row_done <= 1'b1;
              state    <= row_idle;
            end else begin
              col_idx <= col_idx + 1'b1;
              state   <= row_wait_elem;
            end
          end
        end
        default: begin
          state <= row_idle;
        end
      endcase
    end
  end

endmodule

// File: tb_sinh_matrix_sequencer.sv
//////////////////////////////
// Testbench for the matrix sinh accelerator
// Reads sinh_matrix_input.txt from the run directory
// Expected results in the file are Q4.12 hex
// One element in flight, next one after DATA_OUT_J_ENABLE
//////////////////////////////

`timescale 1ns/1ps
`include "sinh_params.svh"

module tb_sinh_matrix_sequencer ();

  localparam int RST_CYCLES  = 5;
  localparam int RESULT_WAIT = 40;

  //////////////////////////////
  // DUT signals
  //////////////////////////////

  logic                    CLK;
  logic                    RST;
  logic                    start;
  logic                    data_in_i_en;
  logic                    data_in_j_en;
  logic [`SINH_SIZE_W-1:0] size_i;
  logic [`SINH_SIZE_W-1:0] size_j;
  logic [`SINH_DATA_W-1:0] data_in;
  logic                    ready;
  logic                    data_out_i_en;
  logic                    data_out_j_en;
  logic [`SINH_DATA_W-1:0] data_out;

  // Records and elements from the input file
  int          rec_test[$];
  int          rec_height[$];
  int          rec_width[$];
  int          rec_stray[$];
  int          rec_first[$];
  logic [31:0] elem_in[$];
  logic [31:0] elem_exp[$];

  // Bookkeeping
  int   errors = 0;
  int   results_total = 0;
  int   j_count = 0;
  int   i_count = 0;
  int   ready_count = 0;
  int   watchdog_ns = 0;
  logic limit_set = 1'b0;

  sinh_matrix_sequencer UUT (
    .CLK               (CLK),
    .RST               (RST),
    .START             (start),
    .DATA_IN_I_ENABLE  (data_in_i_en),
    .DATA_IN_J_ENABLE  (data_in_j_en),
    .SIZE_I_IN         (size_i),
    .SIZE_J_IN         (size_j),
    .DATA_IN           (data_in),
    .READY             (ready),
    .DATA_OUT_I_ENABLE (data_out_i_en),
    .DATA_OUT_J_ENABLE (data_out_j_en),
    .DATA_OUT          (data_out)
  );

  // 40 ns clock
  always #20 CLK = ~CLK;

  // Strobe counters, sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST) begin
      if (data_out_j_en) j_count = j_count + 1;
      if (data_out_i_en) i_count = i_count + 1;
      if (ready) ready_count = ready_count + 1;
    end
  end

  //////////////////////////////
  // Tasks
  //////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic load_stimulus();
    int                  fd;
    int                  n;
    int                  t;
    int                  h;
    int                  w;
    int                  s;
    logic [31:0]         a;
    logic [31:0]         b;
    logic [8*128-1:0]    line_buf;
    fd = $fopen("sinh_matrix_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open sinh_matrix_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        if (n > 0) begin
          // Record header, element line, or comment
          if ($sscanf(line_buf, "T %d %d %d %d", t, h, w, s) == 4) begin
            rec_test.push_back(t);
            rec_height.push_back(h);
            rec_width.push_back(w);
            rec_stray.push_back(s);
            rec_first.push_back(elem_in.size());
          end else if ($sscanf(line_buf, "%h %h", a, b) == 2) begin
            elem_in.push_back(a);
            elem_exp.push_back(b);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic start_matrix(input int height, input int width);
    @(posedge CLK);
    start  <= 1'b1;
    size_i <= height[`SINH_SIZE_W-1:0];
    size_j <= width[`SINH_SIZE_W-1:0];
    @(posedge CLK);
    start  <= 1'b0;
  endtask

  // I strobe opens a row, J strobe for the rest
  task automatic send_element(input logic row_start, input logic [31:0] value);
    @(posedge CLK);
    if (row_start) data_in_i_en <= 1'b1;
    else data_in_j_en <= 1'b1;
    data_in <= value[`SINH_DATA_W-1:0];
    @(posedge CLK);
    data_in_i_en <= 1'b0;
    data_in_j_en <= 1'b0;
  endtask

  // Extra J strobe in the cycle the scalar result returns
  // Scalar unit is idle again, row still busy
  task automatic send_stray_strobe();
    repeat (8) @(posedge CLK);
    data_in_j_en <= 1'b1;
    data_in      <= 16'h5a5a;
    @(posedge CLK);
    data_in_j_en <= 1'b0;
  endtask

  task automatic wait_result(output logic seen);
    int cycles;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < RESULT_WAIT) begin
      @(negedge CLK);
      seen = data_out_j_en;
      cycles++;
    end
  endtask

  task automatic run_test(input int k);
    int   height;
    int   width;
    int   base;
    int   idx;
    int   r;
    int   c;
    int   errors_before;
    int   results;
    logic seen;
    logic last_row;
    logic last_col;
    height        = rec_height[k];
    width         = rec_width[k];
    base          = rec_first[k];
    errors_before = errors;
    results       = 0;
    j_count       = 0;
    i_count       = 0;
    ready_count   = 0;
    if (base + height * width > elem_in.size()) begin
      $display("Test %0d has fewer elements in the input file than its size", rec_test[k]);
      errors++;
    end else begin
      start_matrix(height, width);
      for (r = 0; r < height; r++) begin
        for (c = 0; c < width; c++) begin
          idx = base + r * width + c;
          send_element(c == 0, elem_in[idx]);
          if (rec_stray[k] != 0) send_stray_strobe();
          wait_result(seen);
          if (!seen) begin
            $display("Test %0d element %0d gave no DATA_OUT_J_ENABLE", rec_test[k], idx - base);
            errors++;
          end else begin
            results++;
            last_col = (c == width - 1);
            last_row = (r == height - 1);
            check_value("DATA_OUT", data_out, elem_exp[idx]);
            // Row and matrix ends come with the J strobe
            check_value("READY", ready, last_row && last_col);
            check_value("DATA_OUT_I_ENABLE", data_out_i_en, last_col && !last_row);
          end
        end
      end
      // Let the counters take the last strobes
      @(posedge CLK);
      check_value("DATA_OUT_J_ENABLE count", j_count, height * width);
      check_value("DATA_OUT_I_ENABLE count", i_count, height - 1);
      check_value("READY count", ready_count, 1);
    end
    results_total += results;
    $display("Test %0d (%0dx%0d) done, %0d results, %0d failed checks",
             rec_test[k], height, width, results, errors - errors_before);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    CLK          = 1'b0;
    RST          = 1'b1;
    start        = 1'b0;
    data_in_i_en = 1'b0;
    data_in_j_en = 1'b0;
    size_i       = '0;
    size_j       = '0;
    data_in      = '0;

    load_stimulus();
    if (rec_test.size() == 0) begin
      $display("No test records found in sinh_matrix_input.txt");
      errors++;
    end

    // 12 cycles per element, 20 per test, plus reset
    watchdog_ns = (elem_in.size() * 12 + rec_test.size() * 20 + 10) * 40;
    limit_set   = 1'b1;

    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b0;

    // Outputs idle after reset
    @(negedge CLK);
    check_value("READY", ready, 0);
    check_value("DATA_OUT_I_ENABLE", data_out_i_en, 0);
    check_value("DATA_OUT_J_ENABLE", data_out_j_en, 0);
    check_value("DATA_OUT", data_out, 0);

    for (int k = 0; k < rec_test.size(); k++) begin
      run_test(k);
    end

    $display("Summary: %0d tests, %0d results, %0d failed checks",
             rec_test.size(), results_total, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog, armed once the file is loaded
  initial begin
    wait (limit_set);
    #(watchdog_ns);
    $display("Run timed out after %0d ns", watchdog_ns);
    $display("Errors found");
    $finish;
  end

endmodule
